/* intc_settings.svh */
// ---------------------------------------------------------------------
// Interrupt and timer block settings: widths, IRQ count, TSC IRQ line
// ---------------------------------------------------------------------

`ifndef INTC_SETTINGS_SVH
`define INTC_SETTINGS_SVH

// Data and MSR width
`define INTC_DW 32

// Number of level IRQ lines
`define INTC_NIRQ 32

// Line that also carries the timestamp counter interrupt
`define INTC_TSC_IRQ_LINE 0

// Flops in the IRQ input synchronizer, last one is IRR
`define INTC_SYNC_STAGES 2

// Every line starts masked
`define INTC_IMR_RESET {`INTC_DW{1'b1}}

`endif

/* verilog/intc_pkg.sv */
// ---------------------------------------------------------------------
// Shared types for the IRQC/TSC MSR port and timer control fields
// ---------------------------------------------------------------------

package intc_pkg;

   // Addressable machine-specific registers
   typedef enum logic [1:0]
   {
      MSR_IMR = 2'd0,   // Interrupt mask
      MSR_IRR = 2'd1,   // Interrupt request, read only
      MSR_TSR = 2'd2,   // Timestamp counter
      MSR_TCR = 2'd3    // Timer control
   } msr_sel_e;

   // TCR layout
   // [31] EN, [30] I, [29] P, [27:0] CNT compare value
   localparam int TCR_EN    = 31;  // Counter enable
   localparam int TCR_I     = 30;  // Interrupt enable
   localparam int TCR_P     = 29;  // Pending flag
   localparam int TCR_CNT_W = 28;  // Compare field width

endpackage

/* verilog/tsc.sv */
// ---------------------------------------------------------------------
// Timestamp counter with compare match, sticky pending flag and IRQ
// ---------------------------------------------------------------------

`timescale 1ns/10ps

`include "intc_settings.svh"

module tsc
(
   input                      clk,
   input                      rst_n,
   input  logic               tsr_we,
   input  logic               tcr_we,
   input  logic [`INTC_DW-1:0] wdata,
   output logic [`INTC_DW-1:0] tsr,
   output logic [`INTC_DW-1:0] tcr,
   output logic               tsc_irq
);

   logic [`INTC_DW-1:0]           tsr_q;
   logic [`INTC_DW-1:0]           tcr_q;
   logic [`INTC_DW-1:0]           tsr_nxt;
   logic [`INTC_DW-1:0]           tcr_nxt;
   logic                          cnt_en;
   logic                          cnt_irq_en;
   logic                          cnt_pend;
   logic [intc_pkg::TCR_CNT_W-1:0] cnt_cmp;
   logic                          cnt_hit;

   // Control field decode
   assign cnt_en     = tcr_q[intc_pkg::TCR_EN];
   assign cnt_irq_en = tcr_q[intc_pkg::TCR_I];
   assign cnt_pend   = tcr_q[intc_pkg::TCR_P];
   assign cnt_cmp    = tcr_q[intc_pkg::TCR_CNT_W-1:0];

   // Compare only the low bits covered by CNT
   assign cnt_hit = cnt_en & (tsr_q[intc_pkg::TCR_CNT_W-1:0] == cnt_cmp);

   // Next counter value
   always_comb
   begin
      tsr_nxt = tsr_q;
      if (tsr_we)
      begin
         tsr_nxt = wdata;                     // Write wins over counting
      end
      else if (cnt_en)
      begin
         tsr_nxt = tsr_q + `INTC_DW'(1);
      end
   end

   // Next control value
   always_comb
   begin
      tcr_nxt = tcr_q;
      if (tcr_we)
      begin
         tcr_nxt = wdata;                     // Also the only way to clear P
      end
      else if (cnt_hit)
      begin
         tcr_nxt[intc_pkg::TCR_P] = 1'b1;     // Sticky until rewritten
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tsr_q <= '0;
         tcr_q <= '0;
      end
      else
      begin
         tsr_q <= tsr_nxt;
         tcr_q <= tcr_nxt;
      end
   end

   // Level interrupt while pending and enabled
   assign tsc_irq = cnt_pend & cnt_irq_en;

   assign tsr = tsr_q;
   assign tcr = tcr_q;

endmodule

/* verilog/irqc.sv */
// ---------------------------------------------------------------------
// Interrupt controller: synchronizes level IRQs into IRR, masks by IMR
// ---------------------------------------------------------------------

`timescale 1ns/10ps

`include "intc_settings.svh"

module irqc
(
   input                        clk,
   input                        rst_n,
   input  logic [`INTC_NIRQ-1:0] irqs_lvl,
   input  logic                 ire,
   input  logic                 imr_we,
   input  logic [`INTC_DW-1:0]   wdata,
   output logic [`INTC_DW-1:0]   imr,
   output logic [`INTC_DW-1:0]   irr,
   output logic                 intr
);

   logic [`INTC_NIRQ-1:0] sync_q [`INTC_SYNC_STAGES];
   logic [`INTC_NIRQ-1:0] irr_q;
   logic [`INTC_DW-1:0]   imr_q;
   logic [`INTC_NIRQ-1:0] irq_unmasked;

   // Input synchronizer, lines are asynchronous to clk
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `INTC_SYNC_STAGES; i++)
         begin
            sync_q[i] <= '0;
         end
      end
      else
      begin
         sync_q[0] <= irqs_lvl;
         for (int i = 1; i < `INTC_SYNC_STAGES; i++)
         begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // Last synchronizer stage is the request register
   assign irr_q = sync_q[`INTC_SYNC_STAGES-1];

   // Mask register, a set bit blocks its line
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         imr_q <= `INTC_IMR_RESET;
      end
      else if (imr_we)
      begin
         imr_q <= wdata;
      end
   end

   assign irq_unmasked = irr_q & ~imr_q[`INTC_NIRQ-1:0];

   // No extra flop here, latency is the synchronizer only
   assign intr = ire & (|irq_unmasked);

   assign imr = imr_q;
   assign irr = `INTC_DW'(irr_q);

endmodule

/* verilog/timer_intc_top.sv */
// ---------------------------------------------------------------------
// Timer and interrupt block: TSC IRQ merge, MSR write decode, read mux
// ---------------------------------------------------------------------

`timescale 1ns/10ps

`include "intc_settings.svh"

module timer_intc_top
(
   input                         clk,
   input                         rst_n,
   input  logic [`INTC_NIRQ-1:0]  irqs,
   input  logic                  ire,
   input  logic                  msr_we,
   input  intc_pkg::msr_sel_e    msr_sel,
   input  logic [`INTC_DW-1:0]    msr_wdata,
   output logic [`INTC_DW-1:0]    msr_rdata,
   output logic                  intr
);

   logic [`INTC_NIRQ-1:0] irqs_lvl;
   logic [`INTC_DW-1:0]   tsr;
   logic [`INTC_DW-1:0]   tcr;
   logic [`INTC_DW-1:0]   imr;
   logic [`INTC_DW-1:0]   irr;
   logic                  tsc_irq;
   logic                  tsr_we;
   logic                  tcr_we;
   logic                  imr_we;

   // Per-register write enables, IRR writes are dropped
   assign imr_we = msr_we & (msr_sel == intc_pkg::MSR_IMR);
   assign tsr_we = msr_we & (msr_sel == intc_pkg::MSR_TSR);
   assign tcr_we = msr_we & (msr_sel == intc_pkg::MSR_TCR);

   tsc tsc_i
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .wdata   (msr_wdata),
      .tsr     (tsr),
      .tcr     (tcr),
      .tsc_irq (tsc_irq)
   );

   // Timer IRQ shares its line with the external source
   always_comb
   begin
      irqs_lvl = irqs;
      irqs_lvl[`INTC_TSC_IRQ_LINE] = irqs[`INTC_TSC_IRQ_LINE] | tsc_irq;
   end

   irqc irqc_i
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .irqs_lvl (irqs_lvl),
      .ire      (ire),
      .imr_we   (imr_we),
      .wdata    (msr_wdata),
      .imr      (imr),
      .irr      (irr),
      .intr     (intr)
   );

   // Combinational read-back
   always_comb
   begin
      case (msr_sel)
         intc_pkg::MSR_IMR: msr_rdata = imr;
         intc_pkg::MSR_IRR: msr_rdata = irr;
         intc_pkg::MSR_TSR: msr_rdata = tsr;
         intc_pkg::MSR_TCR: msr_rdata = tcr;
         default:           msr_rdata = '0;
      endcase
   end

endmodule

/* dv/timer_intc_assert.sv */
// ---------------------------------------------------------------------
// Concurrent checks on the timer and interrupt block top level
// ---------------------------------------------------------------------

`timescale 1ns/10ps

`include "intc_settings.svh"

module timer_intc_assert
(
   input logic                clk,
   input logic                rst_n,
   input logic                ire,
   input logic                intr,
   input logic                msr_we,
   input intc_pkg::msr_sel_e  msr_sel,
   input logic [`INTC_DW-1:0] msr_wdata,
   input logic [`INTC_DW-1:0] imr,
   input logic [`INTC_DW-1:0] irr
);

   // Global enable gates the request
   property intr_needs_ire;
      @(posedge clk) disable iff (!rst_n)
         !ire |-> !intr;
   endproperty

   property imr_takes_write;
      @(posedge clk) disable iff (!rst_n)
         (msr_we && (msr_sel == intc_pkg::MSR_IMR)) |=> (imr == $past(msr_wdata));
   endproperty

   // A request needs a line that is pending and not masked
   property intr_has_source;
      @(posedge clk) disable iff (!rst_n)
         intr |-> (|(irr[`INTC_NIRQ-1:0] & ~imr[`INTC_NIRQ-1:0]));
   endproperty

   intr_needs_ire_a: assert property (intr_needs_ire)
      else $error("intr high while ire is low");

   imr_takes_write_a: assert property (imr_takes_write)
      else $error("IMR does not hold the written value");

   intr_has_source_a: assert property (intr_has_source)
      else $error("intr high without an unmasked IRR bit");

endmodule

bind timer_intc_top timer_intc_assert assert_i
(
   .clk       (clk),
   .rst_n     (rst_n),
   .ire       (ire),
   .intr      (intr),
   .msr_we    (msr_we),
   .msr_sel   (msr_sel),
   .msr_wdata (msr_wdata),
   .imr       (imr),
   .irr       (irr)
);

/* dv/timer_intc_tb.sv */
// ---------------------------------------------------------------------
// Table-driven testbench for the timer and interrupt block with a model
// ---------------------------------------------------------------------

`timescale 1ns/10ps

`include "intc_settings.svh"

module timer_intc_tb;

   typedef enum logic [2:0]
   {
      ACT_WRITE,      // MSR write of data
      ACT_READ,       // Compare msr_rdata with expected
      ACT_IDLE,       // Data gives the idle cycle count
      ACT_IRQS,       // Drive the line vector
      ACT_IRE,        // Drive the global enable
      ACT_INTR,       // Compare intr with expected
      ACT_WAIT_INTR   // Data gives the timeout in cycles
   } action_e;

   logic                  clk;
   logic                  rst_n;
   logic [`INTC_NIRQ-1:0] irqs;
   logic                  ire;
   logic                  msr_we;
   intc_pkg::msr_sel_e    msr_sel;
   logic [`INTC_DW-1:0]   msr_wdata;
   logic [`INTC_DW-1:0]   msr_rdata;
   logic                  intr;

   // Step table columns
   string                 step_name [$];
   action_e               step_act [$];
   intc_pkg::msr_sel_e    step_sel [$];
   logic [`INTC_DW-1:0]   step_data [$];
   logic [`INTC_DW-1:0]   step_exp [$];

   // Cycle model state
   logic [`INTC_DW-1:0]   m_imr;
   logic [`INTC_NIRQ-1:0] m_sync;
   logic [`INTC_NIRQ-1:0] m_irr;
   logic [`INTC_DW-1:0]   m_tsr;
   logic [`INTC_DW-1:0]   m_tcr;
   logic                  m_tsc_irq;
   logic                  m_intr;

   logic [31:0]           lfsr_state;

   timer_intc_top dut_i
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .irqs      (irqs),
      .ire       (ire),
      .msr_we    (msr_we),
      .msr_sel   (msr_sel),
      .msr_wdata (msr_wdata),
      .msr_rdata (msr_rdata),
      .intr      (intr)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   assign m_tsc_irq = m_tcr[intc_pkg::TCR_P] & m_tcr[intc_pkg::TCR_I];
   assign m_intr    = ire & (|(m_irr & ~m_imr[`INTC_NIRQ-1:0]));

   // Sees the inputs as they were just before the edge
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         m_imr  <= `INTC_IMR_RESET;
         m_sync <= '0;
         m_irr  <= '0;
         m_tsr  <= '0;
         m_tcr  <= '0;
      end
      else
      begin
         m_sync <= irqs | (`INTC_NIRQ'(m_tsc_irq) << `INTC_TSC_IRQ_LINE);
         m_irr  <= m_sync;                           // Second stage
         if (msr_we && (msr_sel == intc_pkg::MSR_IMR))
         begin
            m_imr <= msr_wdata;
         end
         if (msr_we && (msr_sel == intc_pkg::MSR_TSR))
         begin
            m_tsr <= msr_wdata;
         end
         else if (m_tcr[intc_pkg::TCR_EN])
         begin
            m_tsr <= m_tsr + 32'd1;
         end
         if (msr_we && (msr_sel == intc_pkg::MSR_TCR))
         begin
            m_tcr <= msr_wdata;
         end
         else if (m_tcr[intc_pkg::TCR_EN] &&
                  (m_tsr[intc_pkg::TCR_CNT_W-1:0] == m_tcr[intc_pkg::TCR_CNT_W-1:0]))
         begin
            m_tcr[intc_pkg::TCR_P] <= 1'b1;
         end
      end
   end

   function automatic logic [`INTC_DW-1:0] model_rdata(intc_pkg::msr_sel_e sel);
      case (sel)
         intc_pkg::MSR_IMR: return m_imr;
         intc_pkg::MSR_IRR: return `INTC_DW'(m_irr);
         intc_pkg::MSR_TSR: return m_tsr;
         default:           return m_tcr;
      endcase
   endfunction

   // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
      begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      return out;
   endfunction

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val = {val[30:0], lfsr_bit()};
      end
      return val;
   endfunction

   function automatic void add_step(string name, action_e act, intc_pkg::msr_sel_e sel,
                                    logic [`INTC_DW-1:0] data, logic [`INTC_DW-1:0] exp);
      step_name.push_back(name);
      step_act.push_back(act);
      step_sel.push_back(sel);
      step_data.push_back(data);
      step_exp.push_back(exp);
   endfunction

   task automatic check(string name, logic [`INTC_DW-1:0] exp, logic [`INTC_DW-1:0] act);
      if (act !== exp)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1, "value check failed in step %s", name);
      end
   endtask

   task automatic check_model(string name);
      check({name, " rdata"}, model_rdata(msr_sel), msr_rdata);
      check({name, " intr"}, `INTC_DW'(m_intr), `INTC_DW'(intr));
   endtask

   task automatic idle_cycle(string name);
      @(posedge clk);
      msr_we <= 1'b0;
      @(negedge clk);                                 // Outputs settled here
      check_model(name);
   endtask

   task automatic build_table();
      logic [`INTC_DW-1:0] val;
      logic [`INTC_DW-1:0] mask;
      logic [`INTC_DW-1:0] lines;
      logic [`INTC_DW-1:0] en;
      logic [`INTC_DW-1:0] start;
      logic [`INTC_DW-1:0] n;
      logic [`INTC_DW-1:0] cnt_mask;
      logic [`INTC_DW-1:0] tcr_arm;
      cnt_mask = (32'd1 << intc_pkg::TCR_CNT_W) - 32'd1;
      add_step("reset_imr", ACT_READ, intc_pkg::MSR_IMR, '0, `INTC_IMR_RESET);
      add_step("reset_irr", ACT_READ, intc_pkg::MSR_IRR, '0, '0);
      add_step("reset_tsr", ACT_READ, intc_pkg::MSR_TSR, '0, '0);
      add_step("reset_tcr", ACT_READ, intc_pkg::MSR_TCR, '0, '0);
      add_step("reset_intr", ACT_INTR, intc_pkg::MSR_IMR, '0, '0);
      for (int i = 0; i < 8; i++)
      begin
         val = rand_bits(32);
         add_step("imr_write", ACT_WRITE, intc_pkg::MSR_IMR, val, '0);
         add_step("imr_readback", ACT_READ, intc_pkg::MSR_IMR, '0, val);
      end
      add_step("irr_write", ACT_WRITE, intc_pkg::MSR_IRR, rand_bits(32), '0);
      add_step("irr_unchanged", ACT_READ, intc_pkg::MSR_IRR, '0, '0);
      for (int i = 0; i < 12; i++)
      begin
         mask  = rand_bits(32);
         lines = rand_bits(`INTC_NIRQ);
         if (i % 3 == 1)
         begin
            mask = mask | lines;                      // Every pending line masked
            en   = 32'd1;
         end
         else if (i % 3 == 2)
         begin
            en = 32'd0;                               // Global enable off
         end
         else
         begin
            en = rand_bits(1);
         end
         add_step("mask_imr", ACT_WRITE, intc_pkg::MSR_IMR, mask, '0);
         add_step("mask_ire", ACT_IRE, intc_pkg::MSR_IMR, en, '0);
         add_step("mask_irqs", ACT_IRQS, intc_pkg::MSR_IRR, lines, '0);
         add_step("mask_sync", ACT_IDLE, intc_pkg::MSR_IRR, 2, '0);
         add_step("mask_irr", ACT_READ, intc_pkg::MSR_IRR, '0, lines);
         add_step("mask_intr", ACT_INTR, intc_pkg::MSR_IMR, '0,
                  {31'd0, en[0] & (|(lines & ~mask))});
      end
      // Counter runs with CNT out of reach
      start = rand_bits(16);
      n     = 32'd10 + rand_bits(4);
      add_step("cnt_irqs_off", ACT_IRQS, intc_pkg::MSR_TSR, '0, '0);
      add_step("cnt_ire_off", ACT_IRE, intc_pkg::MSR_TSR, '0, '0);
      add_step("cnt_tsr_write", ACT_WRITE, intc_pkg::MSR_TSR, start, '0);
      add_step("cnt_tsr_hold", ACT_READ, intc_pkg::MSR_TSR, '0, start);
      add_step("cnt_enable", ACT_WRITE, intc_pkg::MSR_TCR,
               (32'd1 << intc_pkg::TCR_EN) | cnt_mask, '0);
      add_step("cnt_run", ACT_IDLE, intc_pkg::MSR_TSR, n, '0);
      add_step("cnt_tsr_adv", ACT_READ, intc_pkg::MSR_TSR, '0, start + n);
      // Compare match a few counts ahead
      start   = rand_bits(16);
      tcr_arm = (32'd1 << intc_pkg::TCR_EN) | (32'd1 << intc_pkg::TCR_I) |
                ((start + 32'd5) & cnt_mask);
      add_step("tmr_stop", ACT_WRITE, intc_pkg::MSR_TCR, '0, '0);
      add_step("tmr_imr", ACT_WRITE, intc_pkg::MSR_IMR,
               ~(32'd1 << `INTC_TSC_IRQ_LINE), '0);
      add_step("tmr_ire", ACT_IRE, intc_pkg::MSR_IMR, 1, '0);
      add_step("tmr_tsr", ACT_WRITE, intc_pkg::MSR_TSR, start, '0);
      add_step("tmr_arm", ACT_WRITE, intc_pkg::MSR_TCR, tcr_arm, '0);
      add_step("tmr_wait", ACT_WAIT_INTR, intc_pkg::MSR_TCR, 40, '0);
      add_step("tmr_pend", ACT_READ, intc_pkg::MSR_TCR, '0,
               tcr_arm | (32'd1 << intc_pkg::TCR_P));
      add_step("tmr_clear", ACT_WRITE, intc_pkg::MSR_TCR,
               (32'd1 << intc_pkg::TCR_EN) | (32'd1 << intc_pkg::TCR_I) | cnt_mask, '0);
      add_step("tmr_sync1", ACT_INTR, intc_pkg::MSR_TCR, '0, 1);
      add_step("tmr_sync2", ACT_INTR, intc_pkg::MSR_TCR, '0, 1);
      add_step("tmr_drop", ACT_INTR, intc_pkg::MSR_TCR, '0, '0);
   endtask

   task automatic run_step(int idx);
      string               name;
      logic [`INTC_DW-1:0] data;
      int                  waited;
      name   = step_name[idx];
      data   = step_data[idx];
      waited = 0;
      @(posedge clk);
      msr_we  <= 1'b0;
      msr_sel <= step_sel[idx];
      case (step_act[idx])
         ACT_WRITE:
         begin
            msr_we    <= 1'b1;
            msr_wdata <= data;
         end
         ACT_IRQS: irqs <= data[`INTC_NIRQ-1:0];
         ACT_IRE:  ire  <= data[0];
         default:  ;
      endcase
      @(negedge clk);
      check_model(name);
      case (step_act[idx])
         ACT_READ: check(name, step_exp[idx], msr_rdata);
         ACT_INTR: check(name, step_exp[idx], `INTC_DW'(intr));
         ACT_IDLE:
         begin
            for (int i = 1; i < int'(data); i++)      // This step was the first
            begin
               idle_cycle(name);
            end
         end
         ACT_WAIT_INTR:
         begin
            while (!intr)
            begin
               if (waited >= int'(data))
               begin
                  $display("Timeout in step %s: intr stayed low for %0d cycles", name, waited);
                  $display("TESTS FAILED");
                  $fatal(1, "timeout waiting for intr");
               end
               else
               begin
                  idle_cycle(name);
                  waited++;
               end
            end
         end
         default: ;
      endcase
   endtask

   initial
   begin
      rst_n      = 1'b0;
      irqs       = '0;
      ire        = 1'b0;
      msr_we     = 1'b0;
      msr_sel    = intc_pkg::MSR_IMR;
      msr_wdata  = '0;
      lfsr_state = 32'hc7bc;
      build_table();
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < step_name.size(); i++)
      begin
         run_step(i);
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* files.f */
+incdir+.
verilog/intc_pkg.sv
verilog/tsc.sv
verilog/irqc.sv
verilog/timer_intc_top.sv
dv/timer_intc_assert.sv
dv/timer_intc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the timer and interrupt testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtimer_intc_tb

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f files.f --top-module timer_intc_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "ERROR: Verilator build failed"
   exit 1
fi

if [ ! -x "$BIN" ]; then
   echo "ERROR: simulation binary $BIN not found"
   exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
fi

# The log decides the result
if grep -qx "TESTS PASSED" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi

echo "ERROR: pass message not found in $LOG"
exit 1
